// File: Makefile
# Verilator flow for the data cache.
# Any variable can be overridden on the command line, e.g. make sim LOG=run.log

VERILATOR  ?= verilator
TOP        ?= cache_tb
LINT_TOP   ?= cache_top
FILELIST   ?= compile.f
LOG        ?= sim.log
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || \
		(echo "simulation ended without a result, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: compile.f
+incdir+dv
hw/cache_pkg.sv
hw/backing_mem.sv
hw/cache_line_store.sv
hw/cache_ctrl.sv
hw/cache_top.sv
dv/cache_tb.sv

// File: dv/cache_ref.svh
`ifndef CACHE_REF_SVH
`define CACHE_REF_SVH

// --------------------
// Reference state.
logic [15:0] ref_mem [32768];
logic [4:0]  ref_tag [256];
logic        ref_valid [256];
logic [31:0] lfsr_state;

// Memory starts as byte address xor 16'hA5C3, cache starts empty.
function automatic void reset_ref_model();
    for (int i = 0; i < 32768; i++) begin
        ref_mem[i] = {i[14:0], 1'b0} ^ 16'hA5C3;
    end
    for (int i = 0; i < 256; i++) begin
        ref_valid[i] = 1'b0;
        ref_tag[i] = '0;
    end
    lfsr_state = 32'h3701_963a;
endfunction

// Taps 32, 22, 2, 1.
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

// One LFSR step per bit taken.
function automatic logic [15:0] take_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v = {v[14:0], lfsr_state[0]};
    end
    return v;
endfunction

// --------------------
// Expected data and hit for one access, then update the model.
function automatic void expect_access(
    input  logic        is_write,
    input  logic [15:0] a,
    input  logic [15:0] wdata,
    output logic [15:0] exp_data,
    output logic        exp_hit
);
    cache_pkg::cache_addr_t split;
    logic [7:0] idx;
    logic [4:0] tg;
    split.flat = a;
    idx = split.fields.index;
    tg = split.fields.tag;
    exp_hit = ref_valid[idx] && (ref_tag[idx] == tg);
    ref_valid[idx] = 1'b1;
    ref_tag[idx] = tg;
    if (is_write) begin
        ref_mem[a[15:1]] = wdata;
    end
    exp_data = ref_mem[a[15:1]];
endfunction

`endif

// File: dv/cache_tb.sv
`timescale 1ns/100ps

module cache_tb;

    localparam int index_bits = 8;
    localparam int mem_latency = 3;
    localparam int num_requests = 313;
    localparam int cycle_limit = num_requests * (4 + 4 + 4 + mem_latency) + 100;

    logic        clk;
    logic        reset;
    logic        rd;
    logic        wr;
    logic [15:0] addr;
    logic [15:0] data_in;
    logic [15:0] data_out;
    logic        stall;
    logic        done;
    logic        cache_hit;

    int error_count = 0;
    int check_count = 0;
    int cycle_count = 0;

    // Expected responses in request order.
    logic [15:0] exp_data_q [$];
    logic        exp_hit_q [$];
    logic [15:0] exp_addr_q [$];
    logic        exp_write_q [$];

    `include "cache_ref.svh"

    cache_top #(
        .index_bits(index_bits),
        .mem_latency(mem_latency)
    ) DUT (
        .clk(clk),
        .reset(reset),
        .rd(rd),
        .wr(wr),
        .addr(addr),
        .data_in(data_in),
        .data_out(data_out),
        .stall(stall),
        .done(done),
        .cache_hit(cache_hit)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // --------------------
    // Request tasks. Entered and left 5 ns after a rising edge.
    task automatic issue_request(input logic is_write, input logic [15:0] a,
                                 input logic [15:0] d);
        logic [15:0] e_data;
        logic        e_hit;
        expect_access(is_write, a, d, e_data, e_hit);
        exp_data_q.push_back(e_data);
        exp_hit_q.push_back(e_hit);
        exp_addr_q.push_back(a);
        exp_write_q.push_back(is_write);
        addr = a;
        data_in = d;
        rd = !is_write;
        wr = is_write;
        @(negedge clk);
        while (!done) begin
            @(negedge clk);
        end
        @(posedge clk);
        #5;
        rd = 1'b0;
        wr = 1'b0;
    endtask

    task automatic do_read(input logic [15:0] a);
        issue_request(1'b0, a, 16'h0000);
    endtask

    task automatic do_write(input logic [15:0] a, input logic [15:0] d);
        issue_request(1'b1, a, d);
    endtask

    task automatic end_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    // --------------------
    // Compare each completed request with the model.
    always @(negedge clk) begin : compare_results
        logic [15:0] e_data;
        logic        e_hit;
        logic [15:0] e_addr;
        logic        e_write;
        if (!reset && done) begin
            if (exp_data_q.size() == 0) begin
                $display("done was seen at %0t with no request pending", $time);
                error_count++;
            end else begin
                e_data = exp_data_q.pop_front();
                e_hit = exp_hit_q.pop_front();
                e_addr = exp_addr_q.pop_front();
                e_write = exp_write_q.pop_front();
                check_count++;
                if (!e_write && data_out !== e_data) begin
                    $display("Fail at %0t: read %h returned %h, expected %h",
                             $time, e_addr, data_out, e_data);
                    error_count++;
                end
                if (cache_hit !== e_hit) begin
                    $display("Fail at %0t: access %h gave cache_hit %b, expected %b",
                             $time, e_addr, cache_hit, e_hit);
                    error_count++;
                end
                if (stall !== 1'b1) begin
                    $display("Fail at %0t: access %h had stall %b in its done cycle",
                             $time, e_addr, stall);
                    error_count++;
                end
            end
        end
    end

    // Run limit.
    initial begin
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: done did not arrive within %0d cycles", cycle_limit);
        $display("CHECKS FAILED");
        $finish;
    end

    // --------------------
    // Main sequence.
    initial begin : main
        int          errs;
        logic [15:0] r;
        logic [4:0]  r_tag;
        logic [7:0]  r_index;
        logic [1:0]  r_word;
        logic        r_write;
        logic [15:0] r_data;
        reset = 1'b1;
        rd = 1'b0;
        wr = 1'b0;
        addr = 16'h0000;
        data_in = 16'h0000;
        reset_ref_model();
        repeat (3) @(posedge clk);
        #5;
        reset = 1'b0;

        errs = error_count;
        @(negedge clk);
        if (stall !== 1'b0 || done !== 1'b0 || cache_hit !== 1'b0) begin
            $display("Fail at %0t: stall, done or cache_hit high after reset", $time);
            error_count++;
        end
        @(posedge clk);
        #5;
        do_read(16'h1234);
        do_read(16'hfffe);
        end_test("reset_and_first_read", errs);

        errs = error_count;
        do_read(16'h1234);
        do_read(16'h1230);
        do_read(16'h1232);
        do_read(16'h1236);
        end_test("repeat_read_hits", errs);

        errs = error_count;
        do_write(16'h1232, 16'hbeef);
        do_read(16'h1232);
        end_test("write_hit", errs);

        // Same index 0x41, tags 4 and 5.
        errs = error_count;
        do_write(16'h2208, 16'h5a5a);
        do_read(16'h2a08);
        do_read(16'h2208);
        end_test("eviction_write_back", errs);

        errs = error_count;
        do_write(16'h5550, 16'h1357);
        do_read(16'h5552);
        end_test("write_miss_allocate", errs);

        // Four tags on four indices keep conflicts frequent.
        errs = error_count;
        for (int n = 0; n < 300; n++) begin
            r = take_bits(2);
            r_tag = {3'b011, r[1:0]};
            r = take_bits(2);
            r_index = {6'h05, r[1:0]};
            r = take_bits(2);
            r_word = r[1:0];
            r = take_bits(1);
            r_write = r[0];
            r_data = take_bits(16);
            if (r_write) begin
                do_write({r_tag, r_index, r_word, 1'b0}, r_data);
            end else begin
                do_read({r_tag, r_index, r_word, 1'b0});
            end
        end
        end_test("random_access", errs);

        if (exp_data_q.size() != 0) begin
            $display("%0d requests finished without a done", exp_data_q.size());
            error_count++;
        end
        $display("summary: %0d responses checked, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: hw/backing_mem.sv
`timescale 1ns/100ps

module backing_mem #(
    parameter int mem_latency = 3
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [cache_pkg::word_width-1:0]  mem_addr,
    input  logic [cache_pkg::word_width-1:0]  mem_wdata,
    input  logic                              mem_wr,
    input  logic                              mem_rd,
    output logic [cache_pkg::word_width-1:0]  mem_rdata,
    output logic                              mem_rvalid
);

    localparam int addr_w = cache_pkg::word_width - 1;
    localparam int depth = 2 ** addr_w;

    logic [cache_pkg::word_width-1:0] mem_array [depth];
    logic [depth-1:0]                 written;
    logic [addr_w-1:0]                word_addr;
    logic [cache_pkg::word_width-1:0] rd_word;
    logic [mem_latency-1:0]           valid_pipe;
    logic [cache_pkg::word_width-1:0] data_pipe [mem_latency];

    assign word_addr = mem_addr[cache_pkg::word_width-1:1];

    // Unwritten words fall back to the seed pattern.
    assign rd_word = written[word_addr] ? mem_array[word_addr]
                                        : cache_pkg::mem_init_word(mem_addr);

    // --------------------
    // Storage.
    always_ff @(posedge clk) begin
        if (reset) begin
            written <= '0;
        end else if (mem_wr) begin
            written[word_addr] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wr) begin
            mem_array[word_addr] <= mem_wdata;
        end
    end

    // --------------------
    // Read pipeline.
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= mem_rd;
            for (int i = 1; i < mem_latency; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        data_pipe[0] <= rd_word;
        for (int i = 1; i < mem_latency; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    assign mem_rvalid = valid_pipe[mem_latency-1];
    assign mem_rdata = data_pipe[mem_latency-1];

    aligned_access: assert property (@(posedge clk) disable iff (reset)
        (mem_rd || mem_wr) |-> !mem_addr[0])
        else $error("unaligned memory access");

endmodule

// File: hw/cache_ctrl.sv
`timescale 1ns/100ps

module cache_ctrl #(
    parameter int index_bits = 8,
    parameter int mem_latency = 3,
    localparam int tag_w = cache_pkg::word_width - index_bits - 3
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              rd,
    input  logic                              wr,
    input  cache_pkg::cache_addr_t            addr,
    input  logic [cache_pkg::word_width-1:0]  data_in,
    input  logic                              hit,
    input  logic                              line_valid,
    input  logic                              line_dirty,
    input  logic [tag_w-1:0]                  victim_tag,
    input  logic [cache_pkg::word_width-1:0]  rd_data,
    input  logic [cache_pkg::word_width-1:0]  mem_rdata,
    input  logic                              mem_rvalid,
    output logic                              stall,
    output logic                              done,
    output logic                              cache_hit,
    output logic [cache_pkg::word_width-1:0]  data_out,
    output logic [index_bits-1:0]             line_index,
    output logic [1:0]                        line_word,
    output logic                              tag_wr,
    output logic                              store_wr,
    output logic [cache_pkg::word_width-1:0]  store_data,
    output logic                              set_dirty,
    output logic                              fill_valid,
    output logic [cache_pkg::word_width-1:0]  mem_addr,
    output logic [cache_pkg::word_width-1:0]  mem_wdata,
    output logic                              mem_wr,
    output logic                              mem_rd
);

    localparam logic [2:0] S_IDLE       = 3'd0;
    localparam logic [2:0] S_COMPARE    = 3'd1;
    localparam logic [2:0] S_WRITE_BACK = 3'd2;
    localparam logic [2:0] S_FILL_ISSUE = 3'd3;
    localparam logic [2:0] S_FILL_WAIT  = 3'd4;
    localparam logic [2:0] S_DONE       = 3'd5;

    localparam int wait_w = $clog2(mem_latency + 1);

    logic [2:0]            state;
    logic [1:0]            beat_cnt;
    logic [1:0]            ret_cnt;
    logic [wait_w-1:0]     wait_cnt;
    logic                  hit_q;
    logic [index_bits-1:0] req_index;
    logic [tag_w-1:0]      req_tag;
    logic [1:0]            req_word;
    logic                  fill_hit_word;

    assign req_index = addr.flat[index_bits+2:3];
    assign req_tag = addr.flat[cache_pkg::word_width-1 -: tag_w];
    assign req_word = addr.fields.word;

    // Returning beat carries the requested word.
    assign fill_hit_word = mem_rvalid && (ret_cnt == req_word);

    // --------------------
    // State register.
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
            beat_cnt <= 2'd0;
            ret_cnt <= 2'd0;
            wait_cnt <= '0;
            hit_q <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (rd || wr) begin
                        state <= S_COMPARE;
                    end
                end
                S_COMPARE: begin
                    hit_q <= hit;
                    beat_cnt <= 2'd0;
                    ret_cnt <= 2'd0;
                    if (hit) begin
                        state <= S_DONE;
                    end else if (line_valid && line_dirty) begin
                        state <= S_WRITE_BACK;
                    end else begin
                        state <= S_FILL_ISSUE;
                    end
                end
                S_WRITE_BACK: begin
                    beat_cnt <= beat_cnt + 2'd1;
                    if (beat_cnt == 2'd3) begin
                        state <= S_FILL_ISSUE;
                    end
                end
                S_FILL_ISSUE: begin
                    beat_cnt <= beat_cnt + 2'd1;
                    if (beat_cnt == 2'd3) begin
                        state <= S_FILL_WAIT;
                        // Last return lands mem_latency cycles after last issue.
                        wait_cnt <= wait_w'(mem_latency - 1);
                    end
                end
                S_FILL_WAIT: begin
                    wait_cnt <= wait_cnt - 1'b1;
                    if (wait_cnt == '0) begin
                        state <= S_DONE;
                    end
                end
                S_DONE: begin
                    state <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
            if (mem_rvalid) begin
                ret_cnt <= ret_cnt + 2'd1;
            end
        end
    end

    // Writes echo their data.
    always_ff @(posedge clk) begin
        if (state == S_COMPARE) begin
            data_out <= wr ? data_in : rd_data;
        end else if (rd && fill_hit_word) begin
            data_out <= mem_rdata;
        end
    end

    // --------------------
    // Responses and line store / memory controls.
    always_comb begin
        stall = (state != S_IDLE);
        done = (state == S_DONE);
        cache_hit = (state == S_DONE) && hit_q;
        line_index = req_index;
        line_word = req_word;
        tag_wr = 1'b0;
        store_wr = 1'b0;
        store_data = data_in;
        set_dirty = 1'b0;
        fill_valid = 1'b0;
        mem_addr = {req_tag, req_index, beat_cnt, 1'b0};
        mem_wdata = rd_data;
        mem_wr = 1'b0;
        mem_rd = 1'b0;
        case (state)
            S_COMPARE: begin
                if (hit && wr) begin
                    store_wr = 1'b1;
                    set_dirty = 1'b1;
                end
            end
            S_WRITE_BACK: begin
                line_word = beat_cnt;
                mem_addr = {victim_tag, req_index, beat_cnt, 1'b0};
                mem_wr = 1'b1;
            end
            S_FILL_ISSUE: begin
                mem_rd = 1'b1;
            end
            default: begin
            end
        endcase
        // Fill beats may overlap the issue cycles.
        if (mem_rvalid) begin
            line_word = ret_cnt;
            store_wr = 1'b1;
            tag_wr = 1'b1;
            fill_valid = 1'b1;
            set_dirty = wr;
            store_data = (wr && fill_hit_word) ? data_in : mem_rdata;
        end
    end

    // --------------------
    // Checks.
    no_rd_wr_overlap: assert property (@(posedge clk) disable iff (reset)
        !(mem_rd && mem_wr))
        else $error("mem_rd and mem_wr high together");

    single_done: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else $error("done high for two cycles");

endmodule

// File: hw/cache_line_store.sv
`timescale 1ns/100ps

module cache_line_store #(
    parameter int index_bits = 8,
    localparam int tag_w = cache_pkg::word_width - index_bits - 3
) (
    input  logic                              clk,
    input  logic                              reset,
    input  cache_pkg::cache_addr_t            addr,
    input  logic [index_bits-1:0]             line_index,
    input  logic [1:0]                        line_word,
    input  logic                              tag_wr,
    input  logic                              store_wr,
    input  logic [cache_pkg::word_width-1:0]  store_data,
    input  logic                              set_dirty,
    input  logic                              fill_valid,
    output logic                              hit,
    output logic                              line_valid,
    output logic                              line_dirty,
    output logic [tag_w-1:0]                  victim_tag,
    output logic [cache_pkg::word_width-1:0]  rd_data
);

    localparam int lines = 2 ** index_bits;

    logic [tag_w-1:0]                 tag_mem [lines];
    logic [lines-1:0]                 valid_bits;
    logic [lines-1:0]                 dirty_bits;
    logic [cache_pkg::word_width-1:0] data_mem [lines][cache_pkg::words_per_line];
    logic [tag_w-1:0]                 addr_tag;

    assign addr_tag = addr.flat[cache_pkg::word_width-1 -: tag_w];

    // --------------------
    // Lookup.
    assign victim_tag = tag_mem[line_index];
    assign line_valid = valid_bits[line_index];
    assign line_dirty = dirty_bits[line_index];
    assign hit = line_valid && (victim_tag == addr_tag);
    assign rd_data = data_mem[line_index][line_word];

    // --------------------
    // Valid and dirty flags.
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (fill_valid) begin
            valid_bits[line_index] <= 1'b1;
            dirty_bits[line_index] <= set_dirty;
        end else if (set_dirty) begin
            dirty_bits[line_index] <= 1'b1;
        end
    end

    // Tags and data.
    always_ff @(posedge clk) begin
        if (tag_wr) begin
            tag_mem[line_index] <= addr_tag;
        end
        if (store_wr) begin
            data_mem[line_index][line_word] <= store_data;
        end
    end

    // A write into a line held for another tag must be a fill.
    no_stale_write: assert property (@(posedge clk) disable iff (reset)
        (store_wr && !hit) |-> (tag_wr && fill_valid))
        else $error("store write to a replaced line without tag write");

endmodule

// File: hw/cache_pkg.sv
package cache_pkg;

    // --------------------
    // Widths.
    localparam int word_width = 16;
    localparam int tag_width = 5;
    localparam int words_per_line = 4;
    localparam int offset_width = $clog2(words_per_line);

    // Index bits left over for the default geometry.
    localparam int index_width = word_width - tag_width - offset_width - 1;

    // --------------------
    // Address word, read flat or split into fields.
    typedef union packed {
        logic [word_width-1:0] flat;
        struct packed {
            logic [tag_width-1:0]    tag;
            logic [index_width-1:0]  index;
            logic [offset_width-1:0] word;
            logic                    byte_sel;
        } fields;
    } cache_addr_t;

    // --------------------
    // Initial memory content at an aligned address.
    function automatic logic [word_width-1:0] mem_init_word(
        input logic [word_width-1:0] addr
    );
        logic [word_width-1:0] value;
        value = addr ^ 16'hA5C3;
        return value;
    endfunction

endpackage

// File: hw/cache_top.sv
`timescale 1ns/100ps

module cache_top #(
    parameter int index_bits = 8,
    parameter int mem_latency = 3
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              rd,
    input  logic                              wr,
    input  logic [cache_pkg::word_width-1:0]  addr,
    input  logic [cache_pkg::word_width-1:0]  data_in,
    output logic [cache_pkg::word_width-1:0]  data_out,
    output logic                              stall,
    output logic                              done,
    output logic                              cache_hit
);

    localparam int tag_w = cache_pkg::word_width - index_bits - 3;

    // --------------------
    // Controller to line store.
    logic [index_bits-1:0]            line_index;
    logic [1:0]                       line_word;
    logic                             tag_wr;
    logic                             store_wr;
    logic [cache_pkg::word_width-1:0] store_data;
    logic                             set_dirty;
    logic                             fill_valid;
    logic                             hit;
    logic                             line_valid;
    logic                             line_dirty;
    logic [tag_w-1:0]                 victim_tag;
    logic [cache_pkg::word_width-1:0] rd_data;

    // Controller to memory.
    logic [cache_pkg::word_width-1:0] mem_addr;
    logic [cache_pkg::word_width-1:0] mem_wdata;
    logic                             mem_wr;
    logic                             mem_rd;
    logic [cache_pkg::word_width-1:0] mem_rdata;
    logic                             mem_rvalid;

    cache_ctrl #(
        .index_bits(index_bits),
        .mem_latency(mem_latency)
    ) u_ctrl (.*);

    cache_line_store #(
        .index_bits(index_bits)
    ) u_store (.*);

    backing_mem #(
        .mem_latency(mem_latency)
    ) u_mem (.*);

endmodule
